// ==== Makefile ====
SRCS := $(wildcard logic/*.sv verif/*.sv verif/*.svh)

.PHONY: run clean

obj_dir/VcoreTb: $(SRCS) verilog.f
	verilator --binary --assert -j 0 --top-module coreTb -f verilog.f

run: obj_dir/VcoreTb
	./obj_dir/VcoreTb | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== logic/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
  input  rvCorePkg::wordT   regData1,
  input  rvCorePkg::wordT   regData2,
  input  rvCorePkg::wordT   pc,
  input  rvCorePkg::wordT   imm,
  input  rvCorePkg::aSelT   aSel,
  input  rvCorePkg::bSelT   bSel,
  input  rvCorePkg::aluOpT  aluOp,
  input  rvCorePkg::funct3T funct3,
  output rvCorePkg::wordT   aluResult,
  output logic              branchTaken
);
  import rvCorePkg::*;

  wordT       opA;
  wordT       opB;
  logic [4:0] shamt;
  logic       regEq;
  logic       regLt;
  logic       regLtu;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operand select and compute
  assign opA   = (aSel == aPc) ? pc : regData1;
  assign opB   = (bSel == bImm) ? imm : regData2;
  assign shamt = opB[4:0];

  always_comb begin
    case (aluOp)
      aluAdd:   aluResult = opA + opB;
      aluSub:   aluResult = opA - opB;
      aluSll:   aluResult = opA << shamt;
      aluSlt:   aluResult = {31'b0, $signed(opA) < $signed(opB)};
      aluSltu:  aluResult = {31'b0, opA < opB};
      aluXor:   aluResult = opA ^ opB;
      aluSrl:   aluResult = opA >> shamt;
      aluSra:   aluResult = $signed(opA) >>> shamt;
      aluOr:    aluResult = opA | opB;
      aluAnd:   aluResult = opA & opB;
      aluPassB: aluResult = opB; // lui.
      default:  aluResult = '0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // branch compare, always on the two registers
  assign regEq  = (regData1 == regData2);
  assign regLt  = ($signed(regData1) < $signed(regData2));
  assign regLtu = (regData1 < regData2);

  always_comb begin
    case (funct3)
      f3Beq:   branchTaken = regEq;
      f3Bne:   branchTaken = !regEq;
      f3Blt:   branchTaken = regLt;
      f3Bge:   branchTaken = !regLt;
      f3Bltu:  branchTaken = regLtu;
      f3Bgeu:  branchTaken = !regLtu;
      default: branchTaken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/coreTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreTop (
  input  logic            clk,
  input  logic            rstN,
  input  rvCorePkg::wordT inst,
  input  rvCorePkg::wordT memRData,
  output rvCorePkg::wordT pc,
  output rvCorePkg::wordT nextPc,
  output rvCorePkg::wordT memAddr,
  output rvCorePkg::wordT memWData,
  output logic            memRead,
  output logic            memWrite,
  output logic            halt
);
  import rvCorePkg::*;

  regAddrT rs1;
  regAddrT rs2;
  regAddrT rd;
  funct3T  funct3;
  immTypeT immType;
  aSelT    aSel;
  bSelT    bSel;
  aluOpT   aluOp;
  wbSelT   wbSel;
  logic    isBranch;
  logic    isJump;
  logic    regWrite;
  logic    branchTaken;
  wordT    imm;
  wordT    aluResult;
  wordT    linkPc;
  wordT    regData1;
  wordT    regData2;

  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];

  assign memAddr  = aluResult; // loads and stores use rs1 + imm.
  assign memWData = regData2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control
  instDecoder uDecoder (
    .rstN     (rstN),
    .inst     (inst),
    .immType  (immType),
    .aSel     (aSel),
    .bSel     (bSel),
    .aluOp    (aluOp),
    .wbSel    (wbSel),
    .isBranch (isBranch),
    .isJump   (isJump),
    .regWrite (regWrite),
    .memRead  (memRead),
    .memWrite (memWrite),
    .halt     (halt)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath
  pcUnit uPc (
    .clk         (clk),
    .rstN        (rstN),
    .isBranch    (isBranch),
    .isJump      (isJump),
    .branchTaken (branchTaken),
    .halt        (halt),
    .aluResult   (aluResult),
    .pc          (pc),
    .nextPc      (nextPc),
    .linkPc      (linkPc)
  );

  regFile uRegs (
    .clk       (clk),
    .rstN      (rstN),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .regWrite  (regWrite),
    .wbSel     (wbSel),
    .aluResult (aluResult),
    .memRData  (memRData),
    .linkPc    (linkPc),
    .regData1  (regData1),
    .regData2  (regData2)
  );

  immGen uImm (
    .inst    (inst),
    .immType (immType),
    .imm     (imm)
  );

  aluUnit uAlu (
    .regData1    (regData1),
    .regData2    (regData2),
    .pc          (pc),
    .imm         (imm),
    .aSel        (aSel),
    .bSel        (bSel),
    .aluOp       (aluOp),
    .funct3      (funct3),
    .aluResult   (aluResult),
    .branchTaken (branchTaken)
  );

endmodule

`default_nettype wire

// ==== logic/immGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module immGen (
  input  rvCorePkg::wordT    inst,
  input  rvCorePkg::immTypeT immType,
  output rvCorePkg::wordT    imm
);
  import rvCorePkg::*;

  logic signBit;

  assign signBit = inst[31]; // every format takes its sign from bit 31.

  always_comb begin
    case (immType)
      immI: imm = {{20{signBit}}, inst[31:20]};
      immS: imm = {{20{signBit}}, inst[31:25], inst[11:7]};
      immB: imm = {{20{signBit}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      immU: imm = {inst[31:12], 12'b0};
      immJ: imm = {{12{signBit}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/instDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instDecoder (
  input  logic                rstN,
  input  rvCorePkg::wordT     inst,
  output rvCorePkg::immTypeT  immType,
  output rvCorePkg::aSelT     aSel,
  output rvCorePkg::bSelT     bSel,
  output rvCorePkg::aluOpT    aluOp,
  output rvCorePkg::wbSelT    wbSel,
  output logic                isBranch,
  output logic                isJump,
  output logic                regWrite,
  output logic                memRead,
  output logic                memWrite,
  output logic                halt
);
  import rvCorePkg::*;

  opcodeT opcode;
  funct3T funct3;
  logic   shiftArith;

  assign opcode     = inst[6:0];
  assign funct3     = inst[14:12];
  assign shiftArith = (funct3 == f3Srl) && inst[30]; // srai shares funct7 bit 5.

  function automatic aluOpT aluFromFunct(input funct3T f3, input logic alt);
    case (f3)
      f3AddSub: return alt ? aluSub : aluAdd;
      f3Sll:    return aluSll;
      f3Slt:    return aluSlt;
      f3Sltu:   return aluSltu;
      f3Xor:    return aluXor;
      f3Srl:    return alt ? aluSra : aluSrl;
      f3Or:     return aluOr;
      f3And:    return aluAnd;
      default:  return aluAdd;
    endcase
  endfunction

  always_comb begin
    immType  = immI;
    aSel     = aReg;
    bSel     = bReg;
    aluOp    = aluAdd;
    wbSel    = wbAlu;
    isBranch = 1'b0;
    isJump   = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    halt     = 1'b0;

    case (opcode)
      opLui: begin
        immType  = immU;
        bSel     = bImm;
        aluOp    = aluPassB;
        regWrite = 1'b1;
      end
      opAuipc: begin
        immType  = immU;
        aSel     = aPc;
        bSel     = bImm;
        regWrite = 1'b1;
      end
      opJal: begin
        immType  = immJ;
        aSel     = aPc;
        bSel     = bImm;
        isJump   = 1'b1;
        regWrite = 1'b1;
        wbSel    = wbLink;
      end
      opJalr: begin
        bSel     = bImm; // target is rs1 + imm.
        isJump   = 1'b1;
        regWrite = 1'b1;
        wbSel    = wbLink;
      end
      opBranch: begin
        immType  = immB;
        aSel     = aPc;
        bSel     = bImm;
        isBranch = (funct3[2:1] != 2'b01); // codes 2 and 3 are reserved.
      end
      opLoad: begin
        bSel     = bImm;
        memRead  = (funct3 == f3Word);
        regWrite = (funct3 == f3Word);
        wbSel    = wbMem;
      end
      opStore: begin
        immType  = immS;
        bSel     = bImm;
        memWrite = (funct3 == f3Word);
      end
      opImm: begin
        bSel     = bImm;
        aluOp    = aluFromFunct(funct3, shiftArith);
        regWrite = 1'b1;
      end
      opReg: begin
        aluOp    = aluFromFunct(funct3, inst[30]);
        regWrite = 1'b1;
      end
      opSystem: halt = (inst == instEbreak);
      default: ; // unknown opcode writes nothing.
    endcase

    if (!rstN) begin
      regWrite = 1'b0;
      memRead  = 1'b0;
      memWrite = 1'b0;
      halt     = 1'b0;
    end
  end

  always_comb begin
    assert (!(memRead && memWrite)) else $error("load and store strobes raised together.");
  end

endmodule

`default_nettype wire

// ==== logic/pcUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcUnit (
  input  logic            clk,
  input  logic            rstN,
  input  logic            isBranch,
  input  logic            isJump,
  input  logic            branchTaken,
  input  logic            halt,
  input  rvCorePkg::wordT aluResult,
  output rvCorePkg::wordT pc,
  output rvCorePkg::wordT nextPc,
  output rvCorePkg::wordT linkPc
);
  import rvCorePkg::*;

  logic redirect;

  assign linkPc   = pc + 32'd4;
  assign redirect = isJump || (isBranch && branchTaken);

  always_comb begin
    if (redirect) begin
      nextPc = {aluResult[31:1], 1'b0}; // jalr drops bit 0.
    end else if (halt) begin
      nextPc = pc; // ebreak parks the core.
    end else begin
      nextPc = linkPc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= resetPc;
    end else begin
      pc <= nextPc;
    end
  end

  // a misaligned target would only come from a bad jump or branch offset.
  pcAligned: assert property (
    @(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00
  ) else $error("pc %h is not word aligned.", pc);

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic               clk,
  input  logic               rstN,
  input  rvCorePkg::regAddrT rs1,
  input  rvCorePkg::regAddrT rs2,
  input  rvCorePkg::regAddrT rd,
  input  logic               regWrite,
  input  rvCorePkg::wbSelT   wbSel,
  input  rvCorePkg::wordT    aluResult,
  input  rvCorePkg::wordT    memRData,
  input  rvCorePkg::wordT    linkPc,
  output rvCorePkg::wordT    regData1,
  output rvCorePkg::wordT    regData2
);
  import rvCorePkg::*;

  wordT regs [1:31]; // x0 has no storage.
  wordT wrData;

  always_comb begin
    case (wbSel)
      wbAlu:   wrData = aluResult;
      wbMem:   wrData = memRData;
      wbLink:  wrData = linkPc;
      default: wrData = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite && (rd != 5'd0)) begin
      regs[rd] <= wrData;
    end
  end

  assign regData1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign regData2 = (rs2 == 5'd0) ? '0 : regs[rs2];

  wbSelValid: assert property (
    @(posedge clk) disable iff (!rstN) regWrite |-> wbSel inside {wbAlu, wbMem, wbLink}
  ) else $error("write-back select %0d is not a valid source.", wbSel);

endmodule

`default_nettype wire

// ==== logic/rvCorePkg.sv ====
`default_nettype none

package rvCorePkg;

  typedef logic [31:0] wordT;
  typedef logic [4:0]  regAddrT;
  typedef logic [2:0]  funct3T;
  typedef logic [6:0]  opcodeT;

  localparam wordT resetPc    = 32'h8000_0000;
  localparam wordT instEbreak = 32'h0010_0073; // whole word, no operands.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // major opcodes
  localparam opcodeT opLui    = 7'b0110111;
  localparam opcodeT opAuipc  = 7'b0010111;
  localparam opcodeT opJal    = 7'b1101111;
  localparam opcodeT opJalr   = 7'b1100111;
  localparam opcodeT opBranch = 7'b1100011;
  localparam opcodeT opLoad   = 7'b0000011;
  localparam opcodeT opStore  = 7'b0100011;
  localparam opcodeT opImm    = 7'b0010011;
  localparam opcodeT opReg    = 7'b0110011;
  localparam opcodeT opSystem = 7'b1110011;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // funct3 codes
  localparam funct3T f3AddSub = 3'b000;
  localparam funct3T f3Sll    = 3'b001;
  localparam funct3T f3Slt    = 3'b010;
  localparam funct3T f3Sltu   = 3'b011;
  localparam funct3T f3Xor    = 3'b100;
  localparam funct3T f3Srl    = 3'b101; // also sra.
  localparam funct3T f3Or     = 3'b110;
  localparam funct3T f3And    = 3'b111;
  localparam funct3T f3Word   = 3'b010; // lw and sw.

  localparam funct3T f3Beq  = 3'b000;
  localparam funct3T f3Bne  = 3'b001;
  localparam funct3T f3Blt  = 3'b100;
  localparam funct3T f3Bge  = 3'b101;
  localparam funct3T f3Bltu = 3'b110;
  localparam funct3T f3Bgeu = 3'b111;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath selects
  typedef enum logic [3:0] {
    aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
    aluSrl, aluSra, aluOr, aluAnd, aluPassB
  } aluOpT;

  typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immTypeT;
  typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSelT;
  typedef enum logic {aReg, aPc} aSelT;
  typedef enum logic {bReg, bImm} bSelT;

endpackage

`default_nettype wire

// ==== verif/coreTbTasks.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction encoders
function automatic wordT encR(input logic [6:0] f7, input regAddrT rs2, input regAddrT rs1,
                              input funct3T f3, input regAddrT rd);
  return {f7, rs2, rs1, f3, rd, opReg};
endfunction

function automatic wordT encI(input logic [11:0] imm, input regAddrT rs1, input funct3T f3,
                              input regAddrT rd, input opcodeT op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic wordT encS(input logic [11:0] imm, input regAddrT rs2, input regAddrT rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
endfunction

function automatic wordT encB(input logic [12:0] imm, input regAddrT rs2, input regAddrT rs1,
                              input funct3T f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
endfunction

function automatic wordT encU(input logic [19:0] imm, input regAddrT rd, input opcodeT op);
  return {imm, rd, op};
endfunction

function automatic wordT encJ(input logic [20:0] imm, input regAddrT rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
endfunction

function automatic wordT pcOf(input int idx);
  return resetPc + wordT'(4 * idx);
endfunction

function automatic wordT nextRand();
  lcgState = lcgState * 32'd1664525 + 32'd1013904223;
  return lcgState;
endfunction

task automatic emit(input wordT w);
  imem[progLen] = w;
  progLen++;
endtask

// always two words, so later addresses are known in advance.
task automatic loadConst(input regAddrT rd, input wordT value);
  wordT hi;
  hi = value + 32'h800;
  emit(encU(hi[31:12], rd, opLui));
  emit(encI(value[11:0], rd, 3'b000, rd, opImm));
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model
function automatic wordT refAlu(input int kind, input wordT a, input wordT b);
  case (kind)
    kAdd:    return a + b;
    kSub:    return a - b;
    kSll:    return a << b[4:0];
    kSlt:    return {31'b0, $signed(a) < $signed(b)};
    kSltu:   return {31'b0, a < b};
    kXor:    return a ^ b;
    kSrl:    return a >> b[4:0];
    kSra:    return wordT'($signed(a) >>> b[4:0]);
    kOr:     return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic refTaken(input funct3T f3, input wordT a, input wordT b);
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return $signed(a) < $signed(b);
    3'b101:  return $signed(a) >= $signed(b);
    3'b110:  return a < b;
    default: return a >= b;
  endcase
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// compare tasks
task automatic checkWord(input wordT got, input wordT exp, input string name);
  if (got !== exp) begin
    $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
    errors++;
  end
endtask

task automatic checkBit(input logic got, input logic exp, input string name);
  if (got !== exp) begin
    $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
    errors++;
  end
endtask

task automatic checkStores();
  checkWord(wordT'(storeAddr.size()), wordT'(expAddr.size()), "store count");
  for (int i = 0; i < storeAddr.size() && i < expAddr.size(); i++) begin
    checkWord(storeAddr[i], expAddr[i], "memAddr");
    checkWord(storeData[i], expData[i], "memWData");
  end
endtask

task automatic checkNextPc(input wordT atPc, input wordT exp);
  int hit;
  hit = -1;
  for (int i = 0; i < pcTrace.size(); i++) begin
    if (hit < 0 && pcTrace[i] == atPc) hit = i;
  end
  if (hit < 0) begin
    $display("instruction at pc %h was never executed", atPc);
    errors++;
  end else begin
    checkWord(nextPcTrace[hit], exp, "nextPc");
  end
endtask

// ==== verif/coreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreTb;
  import rvCorePkg::*;

  localparam int watchdogNs = 6 * 200 * 8; // six tests, 200 cycles each.
  localparam int kAdd  = 0;
  localparam int kSub  = 1;
  localparam int kSll  = 2;
  localparam int kSlt  = 3;
  localparam int kSltu = 4;
  localparam int kXor  = 5;
  localparam int kSrl  = 6;
  localparam int kSra  = 7;
  localparam int kOr   = 8;
  localparam int kAnd  = 9;

  logic clk;
  logic rstN;
  wordT inst;
  wordT memRData;
  wordT pc;
  wordT nextPc;
  wordT memAddr;
  wordT memWData;
  logic memRead;
  logic memWrite;
  logic halt;

  wordT  imem [0:255];
  wordT  dmem [0:255];
  wordT  dataImage [0:255]; // reloaded into dmem during reset.
  wordT  instIdx;
  int    progLen;
  int    errors;
  int    readCount;
  wordT  lcgState;
  string curTest;
  wordT  pcTrace[$];
  wordT  nextPcTrace[$];
  wordT  storeAddr[$];
  wordT  storeData[$];
  wordT  expAddr[$];
  wordT  expData[$];

  `include "coreTbTasks.svh"

  coreTop DUT (
    .clk      (clk),
    .rstN     (rstN),
    .inst     (inst),
    .memRData (memRData),
    .pc       (pc),
    .nextPc   (nextPc),
    .memAddr  (memAddr),
    .memWData (memWData),
    .memRead  (memRead),
    .memWrite (memWrite),
    .halt     (halt)
  );

  always #4 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory models
  assign instIdx  = (pc - resetPc) >> 2;
  assign inst     = imem[instIdx[7:0]];
  assign memRData = memRead ? dmem[memAddr[9:2]] : '0;

  always @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 256; i++) begin
        dmem[i] <= dataImage[i];
      end
    end else if (memWrite) begin
      dmem[memAddr[9:2]] <= memWData;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // program handling
  task automatic newProgram();
    for (int i = 0; i < 256; i++) begin
      imem[i] = instEbreak; // runaway code stops.
    end
    progLen = 0;
    expAddr.delete();
    expData.delete();
  endtask

  task automatic runProgram(input string name);
    logic done;
    curTest = name;
    pcTrace.delete();
    nextPcTrace.delete();
    storeAddr.delete();
    storeData.delete();
    readCount = 0;
    @(posedge clk);
    rstN <= 1'b0;
    repeat (8) begin
      @(negedge clk);
      checkBit(memWrite, 1'b0, "memWrite during reset");
    end
    @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    checkWord(pc, resetPc, "pc after reset");
    done = 1'b0;
    while (!done) begin
      pcTrace.push_back(pc);
      nextPcTrace.push_back(nextPc);
      checkBit(memRead, inst[6:0] == opLoad, "memRead");
      checkBit(memWrite, inst[6:0] == opStore, "memWrite");
      if (memRead) readCount++;
      if (memWrite) begin
        storeAddr.push_back(memAddr);
        storeData.push_back(memWData);
      end
      if (halt) begin
        done = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  task automatic testAluOps();
    funct3T     f3s [0:9] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    int         immKinds [0:8] = '{kAdd, kSlt, kSltu, kXor, kOr, kAnd, kSll, kSrl, kSra};
    wordT       a;
    wordT       b;
    wordT       r;
    logic [11:0] imm;
    int         k;
    newProgram();
    a = nextRand();
    b = nextRand();
    loadConst(5'd1, a);
    loadConst(5'd2, b);
    for (k = 0; k < 10; k++) begin
      emit(encR((k == kSub || k == kSra) ? 7'h20 : 7'h00, 5'd2, 5'd1, f3s[k], 5'd3));
      emit(encS(12'(256 + 4 * k), 5'd3, 5'd0));
      expAddr.push_back(wordT'(256 + 4 * k));
      expData.push_back(refAlu(k, a, b));
    end
    for (int j = 0; j < 9; j++) begin
      r = nextRand();
      imm = r[11:0];
      if (j >= 6) imm = {(immKinds[j] == kSra) ? 7'h20 : 7'h00, r[4:0]};
      emit(encI(imm, 5'd1, f3s[immKinds[j]], 5'd3, opImm));
      emit(encS(12'(256 + 4 * (k + j)), 5'd3, 5'd0));
      expAddr.push_back(wordT'(256 + 4 * (k + j)));
      expData.push_back(refAlu(immKinds[j], a,
                               (j >= 6) ? {27'b0, r[4:0]} : {{20{r[11]}}, r[11:0]}));
    end
    runProgram("alu operations");
    checkStores();
  endtask

  task automatic testUpperImm();
    int auipcIdx;
    newProgram();
    emit(encU(20'hABCDE, 5'd5, opLui));
    auipcIdx = progLen;
    emit(encU(20'h00123, 5'd6, opAuipc));
    emit(encU(20'h12345, 5'd0, opLui));
    emit(encI(12'd7, 5'd5, 3'b000, 5'd0, opImm));
    emit(encS(12'h180, 5'd5, 5'd0));
    emit(encS(12'h184, 5'd6, 5'd0));
    emit(encS(12'h188, 5'd0, 5'd0));
    expAddr = '{32'h180, 32'h184, 32'h188};
    expData = '{32'hABCDE000, pcOf(auipcIdx) + 32'h00123000, 32'h0};
    runProgram("upper immediates and x0");
    checkStores();
  endtask

  task automatic testLoadStore();
    newProgram();
    for (int k = 0; k < 4; k++) begin
      dataImage[64 + k] = nextRand();
    end
    emit(encI(12'h100, 5'd0, 3'b000, 5'd10, opImm));
    for (int k = 0; k < 4; k++) begin
      emit(encI(12'(4 * k), 5'd10, 3'b010, regAddrT'(k + 1), opLoad));
    end
    for (int k = 0; k < 4; k++) begin
      emit(encI(12'd1, regAddrT'(k + 1), 3'b000, regAddrT'(k + 1), opImm));
      emit(encS(12'(64 + 4 * k), regAddrT'(k + 1), 5'd10));
      expAddr.push_back(wordT'(320 + 4 * k));
      expData.push_back(dataImage[64 + k] + 32'd1);
    end
    runProgram("load and store round trip");
    checkStores();
    checkWord(wordT'(readCount), 32'd4, "memRead cycles");
  endtask

  task automatic testBranches();
    funct3T f3s [0:5] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    wordT   opsA [0:3];
    wordT   opsB [0:3];
    wordT   brPc[$];
    wordT   brNext[$];
    wordT   p;
    newProgram();
    opsA[0] = nextRand();
    opsB[0] = opsA[0];
    opsA[1] = 32'hFFFF_FFF0; // negative, but large unsigned.
    opsB[1] = 32'h0000_0007;
    opsA[2] = 32'h0000_0007;
    opsB[2] = 32'hFFFF_FFF0;
    opsA[3] = 32'h0000_0003;
    opsB[3] = 32'h0000_0900;
    for (int f = 0; f < 6; f++) begin
      for (int n = 0; n < 4; n++) begin
        loadConst(5'd1, opsA[n]);
        loadConst(5'd2, opsB[n]);
        p = pcOf(progLen);
        emit(encB(13'd8, 5'd2, 5'd1, f3s[f]));
        emit(encI(12'd0, 5'd0, 3'b000, 5'd0, opImm));
        brPc.push_back(p);
        brNext.push_back(refTaken(f3s[f], opsA[n], opsB[n]) ? p + 32'd8 : p + 32'd4);
      end
    end
    runProgram("branches");
    for (int i = 0; i < brPc.size(); i++) begin
      checkNextPc(brPc[i], brNext[i]);
    end
  endtask

  task automatic testJumps();
    int   jalIdx;
    int   jalrIdx;
    wordT target;
    newProgram();
    jalIdx = progLen;
    emit(encJ(21'd12, 5'd1));
    emit(encI(12'd0, 5'd0, 3'b000, 5'd0, opImm));
    emit(encI(12'd0, 5'd0, 3'b000, 5'd0, opImm));
    jalrIdx = progLen + 2;
    target = pcOf(jalrIdx + 2);
    loadConst(5'd5, target - 32'd2); // plus 3 gives an odd sum.
    emit(encI(12'd3, 5'd5, 3'b000, 5'd2, opJalr));
    emit(encI(12'd0, 5'd0, 3'b000, 5'd0, opImm));
    emit(encS(12'h1C0, 5'd1, 5'd0));
    emit(encS(12'h1C4, 5'd2, 5'd0));
    expAddr = '{32'h1C0, 32'h1C4};
    expData = '{pcOf(jalIdx) + 32'd4, pcOf(jalrIdx) + 32'd4};
    runProgram("jumps");
    checkNextPc(pcOf(jalIdx), pcOf(jalIdx) + 32'd12);
    checkNextPc(pcOf(jalrIdx), target);
    checkStores();
  endtask

  task automatic testHaltReset();
    newProgram();
    emit(encS(12'h1DC, 5'd0, 5'd0)); // sits at resetPc while reset is held.
    emit(encI(12'd5, 5'd0, 3'b000, 5'd1, opImm));
    emit(encI(12'd1, 5'd1, 3'b000, 5'd2, opImm));
    emit(encS(12'h1E0, 5'd2, 5'd0));
    emit(instEbreak);
    expAddr = '{32'h1DC, 32'h1E0};
    expData = '{32'h0, 32'd6};
    runProgram("halt and reset");
    checkStores();
    checkWord(pc, pcOf(4), "pc at halt");
    repeat (10) begin
      @(negedge clk);
      checkBit(halt, 1'b1, "halt");
      checkWord(pc, pcOf(4), "pc");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sequence and watchdog
  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    errors = 0;
    lcgState = 32'd25;
    curTest = "startup";
    for (int i = 0; i < 256; i++) begin
      dataImage[i] = 32'hDA7A_0000 ^ wordT'(i * 257);
    end
    newProgram();
    testAluOps();
    testUpperImm();
    testLoadStore();
    testBranches();
    testJumps();
    testHaltReset();
    $display("run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(watchdogNs);
    $display("watchdog expired, test %s hung before halt", curTest);
    $display("run finished with %0d errors", errors + 1);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verif
logic/rvCorePkg.sv
logic/instDecoder.sv
logic/pcUnit.sv
logic/regFile.sv
logic/immGen.sv
logic/aluUnit.sv
logic/coreTop.sv
verif/coreTb.sv
